// File: build.f
source/cadr_word_pkg.sv
source/cadr_uinst_pkg.sv
source/amem_dpram.sv
source/mmem_regfile.sv
source/alu_unit.sv
source/useq_control.sv
source/cadr_datapath_top.sv
dv/tb_clock.sv
dv/cadr_sva.sv
dv/cadr_tb.sv

// File: dv/cadr_sva.sv
// concurrent checks on the sequencer handshake and write enables, bound into useq_control
`timescale 1ns/1ps

module cadr_sva
   import cadr_uinst_pkg::*;
(
   input logic        clk_a,
   input logic        reset,
   input logic        uinst_valid,
   input logic        busy,
   input logic        done,
   input logic        a_wren,
   input logic        m_wren,
   input useq_state_t state
);

   // done is a single-cycle pulse
   done_one_cycle: assert property (@(posedge clk_a) disable iff (reset) done |=> !done)
      else $error("done held for more than one cycle");

   // busy through read, exec and write up to done
   done_while_busy: assert property (@(posedge clk_a) disable iff (reset)
      done |-> busy && $past(busy) && $past(busy, 2))
      else $error("done seen without busy through the instruction");

   // write-back only in the write state of an accepted instruction
   wren_in_write: assert property (@(posedge clk_a) disable iff (reset)
      (a_wren || m_wren) |-> (state == st_write) && $past(uinst_valid && state == st_idle, 3))
      else $error("memory write enable outside the write state of an accepted instruction");

endmodule

bind useq_control cadr_sva sva0
(
   .clk_a       (clk_a),
   .reset       (reset),
   .uinst_valid (uinst_valid),
   .busy        (busy),
   .done        (done),
   .a_wren      (a_wren),
   .m_wren      (m_wren),
   .state       (state)
);

// File: dv/cadr_tb.sv
// testbench for the datapath top, random microinstructions checked against a model of A and M
`timescale 1ns/1ps

module cadr_tb
   import cadr_word_pkg::*, cadr_uinst_pkg::*;
;

   logic   clk_a;
   logic   reset;
   logic   uinst_valid;
   uinst_t uinst;
   logic   busy;
   logic   done;
   word_t  result;

   word_t      a_mem [0:amem_depth-1];          // modeled A contents
   bit         a_ok  [0:amem_depth-1];
   word_t      m_mem [0:mmem_depth-1];
   bit         m_ok  [0:mmem_depth-1];
   amem_addr_t a_list[$];                       // A words written so far
   mmem_addr_t m_list[$];
   integer     seed;
   int         errors;

   tb_clock clk0 (.clk_a(clk_a));

   cadr_datapath_top dut0
   (
      .clk_a       (clk_a),
      .reset       (reset),
      .uinst_valid (uinst_valid),
      .uinst       (uinst),
      .busy        (busy),
      .done        (done),
      .result      (result)
   );

   task automatic flag_error(input string msg);
      $display("[ERROR] %0t %s", $time, msg);
      errors++;
   endtask

   function automatic word_t model_alu(input alu_op_t op, input word_t a, input word_t m,
                                       input word_t imm);
      case (op)
         alu_add:    return a + m;
         alu_sub:    return a - m;
         alu_and:    return a & m;
         alu_or:     return a | m;
         alu_xor:    return a ^ m;
         alu_pass_a: return a;
         alu_pass_m: return m;
         default:    return imm;
      endcase
   endfunction

   function automatic int pick(input int n);
      return int'($unsigned($random(seed)) % $unsigned(n));
   endfunction

   // sources come from words already written
   function automatic uinst_t make_uinst(input alu_op_t op, input logic wr_a, input logic wr_m);
      uinst_t u;
      u = '0;
      if (a_list.size() > 0)
         u.a_src = a_list[pick(a_list.size())];
      if (m_list.size() > 0)
         u.m_src = m_list[pick(m_list.size())];
      u.op   = op;
      u.wr_a = wr_a;
      u.wr_m = wr_m;
      u.dest = amem_addr_t'($random(seed));
      u.imm  = word_t'($random(seed));
      return u;
   endfunction

   task automatic update_model(input uinst_t u, input word_t val);
      if (u.wr_a)
      begin
         if (!a_ok[u.dest])
            a_list.push_back(u.dest);
         a_ok[u.dest]  = 1'b1;
         a_mem[u.dest] = val;
      end
      if (u.wr_m)
      begin
         if (!m_ok[u.dest[mmem_aw-1:0]])
            m_list.push_back(u.dest[mmem_aw-1:0]);
         m_ok[u.dest[mmem_aw-1:0]]  = 1'b1;
         m_mem[u.dest[mmem_aw-1:0]] = val;
      end
   endtask

   task automatic clear_model();
      for (int i = 0; i < amem_depth; i++)
         a_ok[i] = 1'b0;
      for (int i = 0; i < mmem_depth; i++)
         m_ok[i] = 1'b0;
      a_list.delete();
      m_list.delete();
   endtask

   task automatic apply_reset();
      reset = 1'b1;
      repeat (3) @(negedge clk_a);
      reset = 1'b0;
   endtask

   // called on a falling edge, returns on the first idle falling edge after done
   task automatic run_uinst(input uinst_t u, input bit extra, output word_t res);
      int    cycles;
      word_t expected;
      expected    = model_alu(u.op, a_mem[u.a_src], m_mem[u.m_src], u.imm);
      uinst       = u;
      uinst_valid = 1'b1;
      @(negedge clk_a);                         // accepting edge just passed
      uinst_valid = extra;
      cycles      = 1;
      while (!done && cycles < 10)
      begin
         assert (busy) else flag_error("busy low before done");
         @(negedge clk_a);
         cycles++;
         if (extra)
            uinst = uinst_t'(62'({$random(seed), $random(seed)}));   // stray strobe
      end
      if (!done)
      begin
         $display("timeout: done never arrived at %0t", $time);
         errors++;
         $display("errors: %0d", errors);
         $display("SOME TESTS FAILED");
         $finish;
      end
      else
      begin
         assert (cycles == 3) else flag_error($sformatf("done after %0d cycles", cycles));
         assert (busy) else flag_error("busy low with done");
         assert (result === expected)
            else flag_error($sformatf("result %h expected %h", result, expected));
         res = result;
         update_model(u, expected);
         @(negedge clk_a);                      // strobes, if any, span the write cycle too
         uinst_valid = 1'b0;
         assert (!done && !busy) else flag_error("extra done or busy after write");
         assert (result === res) else flag_error("result did not hold");
      end
   endtask

   initial
   begin
      uinst_t u;
      uinst_t rd;
      word_t  res;
      seed        = 88;
      errors      = 0;
      reset       = 1'b1;
      uinst_valid = 1'b0;
      uinst       = '0;
      clear_model();
      apply_reset();

      // immediates, read back at once from A and M, which one first alternates
      for (int i = 0; i < 40; i++)
      begin
         u = make_uinst(alu_imm, 1'b1, 1'b1);
         run_uinst(u, 1'b0, res);
         rd       = make_uinst(alu_op_t'((i % 2) ? alu_pass_m : alu_pass_a), 1'b0, 1'b0);
         rd.a_src = u.dest;
         rd.m_src = u.dest[mmem_aw-1:0];
         run_uinst(rd, 1'b0, res);
         assert (res === u.imm) else flag_error($sformatf("readback %h expected %h", res, u.imm));
         rd.op = alu_op_t'((i % 2) ? alu_pass_a : alu_pass_m);
         run_uinst(rd, 1'b0, res);
         assert (res === u.imm) else flag_error($sformatf("readback %h expected %h", res, u.imm));
      end

      // every fourth one gets strobes while busy
      for (int i = 0; i < 300; i++)
      begin
         u = make_uinst(alu_op_t'(3'($random(seed))), 1'($random(seed)), 1'($random(seed)));
         run_uinst(u, (i % 4) == 3, res);
      end

      // reset while an instruction is in flight
      u           = make_uinst(alu_imm, 1'b1, 1'b1);
      uinst       = u;
      uinst_valid = 1'b1;
      @(negedge clk_a);
      uinst_valid = 1'b0;
      apply_reset();
      assert (!busy && !done && result === '0) else flag_error("outputs not cleared by reset");
      clear_model();                            // contents undefined now
      for (int i = 0; i < 16; i++)
      begin
         u = make_uinst(alu_imm, 1'b1, 1'b1);
         run_uinst(u, 1'b0, res);
      end
      for (int i = 0; i < 60; i++)
      begin
         u = make_uinst(alu_op_t'(3'($random(seed))), 1'($random(seed)), 1'($random(seed)));
         run_uinst(u, 1'b0, res);
      end

      $display("errors: %0d", errors);
      if (errors == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

// File: dv/tb_clock.sv
// testbench clock source, free-running clk_a with a 10 ns period for the datapath testbench
`timescale 1ns/1ps

module tb_clock
(
   output logic clk_a
);

   localparam int half_period = 5;              // ns

   initial
   begin
      clk_a = 1'b0;
      forever
         #half_period clk_a = ~clk_a;
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the datapath testbench with Verilator, run it, and check for the pass message
set -e

cd "$(dirname "$0")"

verilator --binary --assert --top-module cadr_tb -Mdir obj_dir -f build.f

out=$(./obj_dir/Vcadr_tb || true)
echo "$out"

if echo "$out" | grep -q "ALL TESTS PASSED"; then
   exit 0
else
   exit 1
fi

// File: source/alu_unit.sv
// ALU for the microcoded datapath, computes on the A and M operands and latches the result on capture
`timescale 1ns/1ps

module alu_unit
   import cadr_word_pkg::*;
(
   input  logic    clk_a,
   input  logic    reset,
   input  logic    capture,
   input  alu_op_t op,
   input  word_t   a_val,
   input  word_t   m_val,
   input  word_t   imm,
   output word_t   result
);

   word_t alu_val;                              // unregistered function output

   always_comb
   begin
      case (op)
         alu_add:
            alu_val = a_val + m_val;            // carry out dropped
         alu_sub:
            alu_val = a_val - m_val;
         alu_and:
            alu_val = a_val & m_val;
         alu_or:
            alu_val = a_val | m_val;
         alu_xor:
            alu_val = a_val ^ m_val;
         alu_pass_a:
            alu_val = a_val;
         alu_pass_m:
            alu_val = m_val;
         alu_imm:
            alu_val = imm;
         default:
            alu_val = '0;
      endcase
   end

   // result holds until the next capture
   always_ff @(posedge clk_a)
   begin
      if (reset)
         result <= '0;
      else if (capture)
         result <= alu_val;
   end

endmodule

// File: source/amem_dpram.sv
// A scratchpad memory, 1k x 32 dual-port RAM with registered reads, instantiated by the top level
`timescale 1ns/1ps

module amem_dpram
   import cadr_word_pkg::*;
(
   input  logic       clk_a,
   input  logic       reset,

   input  amem_addr_t address_a,
   input  word_t      data_a,
   input  logic       wren_a,
   input  logic       rden_a,
   output word_t      q_a,

   input  amem_addr_t address_b,
   input  word_t      data_b,
   input  logic       wren_b,
   input  logic       rden_b,
   output word_t      q_b
);

   word_t ram [0:amem_depth-1];                 // contents undefined after reset

   // a single write per cycle, port A wins
   always_ff @(posedge clk_a)
   begin
      if (wren_a)
         ram[address_a] <= data_a;
      else if (wren_b)
         ram[address_b] <= data_b;
   end

   // port A read register
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_a <= '0;
      else if (rden_a)
         q_a <= ram[address_a];                 // old data on same-cycle write
   end

   // port B read register, same clock as port A
   always_ff @(posedge clk_a)
   begin
      if (reset)
         q_b <= '0;
      else if (rden_b)
         q_b <= ram[address_b];
   end

endmodule

// File: source/cadr_datapath_top.sv
// datapath slice top level, joins the sequencer, A-memory, M-memory and ALU
`timescale 1ns/1ps

module cadr_datapath_top
   import cadr_word_pkg::*, cadr_uinst_pkg::*;
(
   input  logic   clk_a,
   input  logic   reset,
   input  logic   uinst_valid,
   input  uinst_t uinst,
   output logic   busy,
   output logic   done,
   output word_t  result
);

   logic       a_rden;
   amem_addr_t a_raddr;
   logic       m_rden;
   mmem_addr_t m_raddr;
   logic       alu_capture;
   alu_op_t    op;
   word_t      imm;
   logic       a_wren;
   amem_addr_t a_waddr;
   logic       m_wren;
   mmem_addr_t m_waddr;
   word_t      a_val;
   word_t      m_val;

   useq_control u_useq
   (
      .clk_a       (clk_a),
      .reset       (reset),
      .uinst_valid (uinst_valid),
      .uinst       (uinst),
      .busy        (busy),
      .done        (done),
      .a_rden      (a_rden),
      .a_raddr     (a_raddr),
      .m_rden      (m_rden),
      .m_raddr     (m_raddr),
      .alu_capture (alu_capture),
      .op          (op),
      .imm         (imm),
      .a_wren      (a_wren),
      .a_waddr     (a_waddr),
      .m_wren      (m_wren),
      .m_waddr     (m_waddr)
   );

   // port A reads operands, port B takes the write-back
   amem_dpram u_amem
   (
      .clk_a     (clk_a),
      .reset     (reset),
      .address_a (a_raddr),
      .data_a    ('0),                          // port A never writes
      .wren_a    (1'b0),
      .rden_a    (a_rden),
      .q_a       (a_val),
      .address_b (a_waddr),
      .data_b    (result),
      .wren_b    (a_wren),
      .rden_b    (1'b0),
      .q_b       ()
   );

   mmem_regfile u_mmem
   (
      .clk_a (clk_a),
      .rden  (m_rden),
      .raddr (m_raddr),
      .rdata (m_val),
      .wren  (m_wren),
      .waddr (m_waddr),
      .wdata (result)
   );

   alu_unit u_alu
   (
      .clk_a   (clk_a),
      .reset   (reset),
      .capture (alu_capture),
      .op      (op),
      .a_val   (a_val),
      .m_val   (m_val),
      .imm     (imm),
      .result  (result)
   );

endmodule

// File: source/cadr_uinst_pkg.sv
// microinstruction format and sequencer states, shared by the sequencer and the top level
package cadr_uinst_pkg;

   import cadr_word_pkg::*;

   // one microinstruction as issued by the host
   typedef struct packed
   {
      amem_addr_t a_src;                        // A operand address
      mmem_addr_t m_src;                        // M operand address
      alu_op_t    op;
      logic       wr_a;                         // write result to A[dest]
      logic       wr_m;                         // write result to M[dest low bits]
      amem_addr_t dest;
      word_t      imm;
   } uinst_t;

   typedef enum logic [1:0]
   {
      st_idle  = 2'd0,
      st_read  = 2'd1,                          // memory reads issued
      st_exec  = 2'd2,                          // operands valid, ALU captures
      st_write = 2'd3                           // write-back and done
   } useq_state_t;

endpackage

// File: source/cadr_word_pkg.sv
// datapath word and address widths, their types, and the ALU operation codes
package cadr_word_pkg;

   localparam int word_w     = 32;              // data word width
   localparam int amem_aw    = 10;              // A-memory address width
   localparam int mmem_aw    = 5;               // M-memory address width
   localparam int amem_depth = 1 << amem_aw;    // 1k A words
   localparam int mmem_depth = 1 << mmem_aw;    // 32 M words
   localparam int alu_op_w   = 3;

   typedef logic [word_w-1:0]  word_t;
   typedef logic [amem_aw-1:0] amem_addr_t;
   typedef logic [mmem_aw-1:0] mmem_addr_t;

   // ALU function select, carried in the op field of a microinstruction
   typedef enum logic [alu_op_w-1:0]
   {
      alu_add    = 3'd0,                        // a + m, wraps at 32 bits
      alu_sub    = 3'd1,                        // a - m
      alu_and    = 3'd2,
      alu_or     = 3'd3,
      alu_xor    = 3'd4,
      alu_pass_a = 3'd5,
      alu_pass_m = 3'd6,
      alu_imm    = 3'd7                         // immediate field
   } alu_op_t;

endpackage

// File: source/mmem_regfile.sv
// M scratch register file, 32 x 32 with one registered read and one write, used by the top level
`timescale 1ns/1ps

module mmem_regfile
   import cadr_word_pkg::*;
(
   input  logic       clk_a,

   input  logic       rden,
   input  mmem_addr_t raddr,
   output word_t      rdata,

   input  logic       wren,
   input  mmem_addr_t waddr,
   input  word_t      wdata
);

   word_t regs [0:mmem_depth-1];

   always_ff @(posedge clk_a)
   begin
      if (wren)
         regs[waddr] <= wdata;
   end

   // data follows the enable by one cycle
   always_ff @(posedge clk_a)
   begin
      if (rden)
         rdata <= regs[raddr];                  // held while rden is low
   end

endmodule

// File: source/useq_control.sv
// microinstruction sequencer, steps one instruction through read, exec and write-back
`timescale 1ns/1ps

module useq_control
   import cadr_word_pkg::*, cadr_uinst_pkg::*;
(
   input  logic       clk_a,
   input  logic       reset,

   input  logic       uinst_valid,
   input  uinst_t     uinst,
   output logic       busy,
   output logic       done,

   output logic       a_rden,
   output amem_addr_t a_raddr,
   output logic       m_rden,
   output mmem_addr_t m_raddr,

   output logic       alu_capture,
   output alu_op_t    op,
   output word_t      imm,

   output logic       a_wren,
   output amem_addr_t a_waddr,
   output logic       m_wren,
   output mmem_addr_t m_waddr
);

   useq_state_t state;
   useq_state_t state_nx;
   uinst_t      cur;                            // instruction in flight
   logic        accept;

   assign accept = (state == st_idle) && uinst_valid;   // strobes while busy are dropped

   always_comb
   begin
      state_nx = state;
      case (state)
         st_idle:
         begin
            if (uinst_valid)
               state_nx = st_read;
         end
         st_read:
            state_nx = st_exec;
         st_exec:
            state_nx = st_write;
         st_write:
            state_nx = st_idle;
         default:
            state_nx = st_idle;
      endcase
   end

   always_ff @(posedge clk_a)
   begin
      if (reset)
         state <= st_idle;
      else
         state <= state_nx;
   end

   always_ff @(posedge clk_a)
   begin
      if (accept)
         cur <= uinst;
   end

   assign busy = (state != st_idle);
   assign done = (state == st_write);           // result is valid in this cycle

   // operand reads, data returns in st_exec
   assign a_rden  = (state == st_read);
   assign a_raddr = cur.a_src;
   assign m_rden  = (state == st_read);
   assign m_raddr = cur.m_src;

   assign alu_capture = (state == st_exec);
   assign op          = cur.op;
   assign imm         = cur.imm;

   // write-back lands on the edge that leaves st_write
   assign a_wren  = (state == st_write) && cur.wr_a;
   assign a_waddr = cur.dest;
   assign m_wren  = (state == st_write) && cur.wr_m;
   assign m_waddr = cur.dest[mmem_aw-1:0];      // M uses the low dest bits

endmodule
